/* design/wb_pkg.sv */
package wb_pkg;

    // Line address, one address per 128-bit line
    localparam int ADDR_W = 12;

    // Full cache line carried in a single transfer
    localparam int DATA_W = 128;

    // One select bit per byte of the line
    localparam int SEL_W = DATA_W / 8;

    // Master side of a single Wishbone transfer
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Slave side, ack closes exactly one transfer
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage : wb_pkg

/* design/evict_pkg.sv */
package evict_pkg;

    // One evicted line waiting for write-back
    typedef struct packed {
        logic                      valid;
        logic [wb_pkg::ADDR_W-1:0] adr;
        logic [wb_pkg::SEL_W-1:0]  sel;
        logic [wb_pkg::DATA_W-1:0] dat;
    } entry_t;

    // Drain sequencing toward the next-level memory
    typedef enum logic {
        idle     = 1'b0,
        draining = 1'b1
    } drain_state_t;

endpackage : evict_pkg

/* design/evict_line_store.sv */
module evict_line_store (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      store_capture,
    input  logic                      store_release,
    input  wb_pkg::wb_req_t           capture_req,
    input  logic [wb_pkg::ADDR_W-1:0] lookup_adr,
    output evict_pkg::entry_t         entry,
    output logic                      hit
);

    logic                      valid_q;
    logic [wb_pkg::ADDR_W-1:0] adr_q;
    logic [wb_pkg::SEL_W-1:0]  sel_q;
    logic [wb_pkg::DATA_W-1:0] dat_q;

    // Valid bit follows capture and release pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (store_capture) begin
            valid_q <= 1'b1;
        end else if (store_release) begin
            valid_q <= 1'b0;
        end
    end

    // Line payload, only meaningful while valid_q is set
    always_ff @(posedge clk) begin
        if (store_capture) begin
            adr_q <= capture_req.adr;
            sel_q <= capture_req.sel;
            dat_q <= capture_req.dat;
        end
    end

    always_comb begin
        entry.valid = valid_q;
        entry.adr   = adr_q;
        entry.sel   = sel_q;
        entry.dat   = dat_q;
    end

    // Address match against the cache request in flight
    assign hit = valid_q && (adr_q == lookup_adr);

    // Single entry, so a new line may only land in an empty store
    capture_when_empty : assert property (
        @(posedge clk) disable iff (reset)
        store_capture |-> !valid_q
    ) else $error("line captured while entry still valid");

    // A release must follow an earlier capture
    release_when_full : assert property (
        @(posedge clk) disable iff (reset)
        store_release |-> valid_q
    ) else $error("line released while entry empty");

endmodule : evict_line_store

/* design/evict_control.sv */
module evict_control (
    input  logic              clk,
    input  logic              reset,
    input  wb_pkg::wb_req_t   orig_req,
    output wb_pkg::wb_rsp_t   orig_rsp,
    output wb_pkg::wb_req_t   dest_req,
    input  wb_pkg::wb_rsp_t   dest_rsp,
    input  evict_pkg::entry_t entry,
    input  logic              hit,
    output logic              store_capture,
    output logic              store_release
);

    evict_pkg::drain_state_t state_q;
    evict_pkg::drain_state_t state_d;

    logic is_draining;
    logic rd_hit;
    logic rd_miss;
    logic wr_req;
    logic pass_through;

    assign is_draining = (state_q == evict_pkg::draining);

    // Only STB qualifies a cache transfer
    assign rd_hit  = orig_req.stb && !orig_req.we && hit;
    assign rd_miss = orig_req.stb && !orig_req.we && !hit;
    assign wr_req  = orig_req.stb && orig_req.we;

    // Memory port is lent to the cache only outside a drain
    assign pass_through = rd_miss && !is_draining;

    // Drain FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            evict_pkg::idle: begin
                // Start once the memory port is left free for a cycle
                if (entry.valid && !pass_through) begin
                    state_d = evict_pkg::draining;
                end
            end
            evict_pkg::draining: begin
                if (dest_rsp.ack) begin
                    state_d = evict_pkg::idle;
                end
            end
            default: begin
                state_d = evict_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= evict_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Cache side response picks pass-through, hit, capture or stall
    always_comb begin
        orig_rsp.ack  = 1'b0;
        orig_rsp.dat  = dest_rsp.dat;
        store_capture = 1'b0;
        if (pass_through) begin
            orig_rsp.ack = dest_rsp.ack;
        end else if (rd_hit) begin
            orig_rsp.ack = 1'b1;
            orig_rsp.dat = entry.dat;
        end else if (wr_req && !entry.valid) begin
            orig_rsp.ack  = 1'b1;
            store_capture = 1'b1;
        end
        // Anything else stalls with ack low
    end

    // Drain write has priority over pass-through on the memory port
    always_comb begin
        dest_req = '0;
        if (is_draining) begin
            dest_req.cyc = 1'b1;
            dest_req.stb = 1'b1;
            dest_req.we  = 1'b1;
            dest_req.sel = entry.sel;
            dest_req.adr = entry.adr;
            dest_req.dat = entry.dat;
        end else if (pass_through) begin
            dest_req = orig_req;
        end
    end

    // Entry is freed on the edge that completes the drain write
    assign store_release = is_draining && dest_rsp.ack;

    // Memory only ever receives a line that the store still holds
    dest_write_in_drain : assert property (
        @(posedge clk) disable iff (reset)
        (dest_req.stb && dest_req.we) |-> entry.valid
    ) else $error("memory write without a held line");

    // A held line stays untouched until the drain releases it
    no_capture_over_entry : assert property (
        @(posedge clk) disable iff (reset)
        (entry.valid && !store_release) |=> $stable(entry)
    ) else $error("held line changed before release");

endmodule : evict_control

/* design/evict_buffer.sv */
module evict_buffer (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t orig_req,
    output wb_pkg::wb_rsp_t orig_rsp,
    output wb_pkg::wb_req_t dest_req,
    input  wb_pkg::wb_rsp_t dest_rsp
);

    evict_pkg::entry_t entry;
    logic              hit;
    logic              store_capture;
    logic              store_release;

    // Single line holding register, looked up by the cache address
    evict_line_store store_i (
        .clk           (clk),
        .reset         (reset),
        .store_capture (store_capture),
        .store_release (store_release),
        .capture_req   (orig_req),
        .lookup_adr    (orig_req.adr),
        .entry         (entry),
        .hit           (hit)
    );

    // Request routing and drain scheduling
    evict_control control_i (
        .clk           (clk),
        .reset         (reset),
        .orig_req      (orig_req),
        .orig_rsp      (orig_rsp),
        .dest_req      (dest_req),
        .dest_rsp      (dest_rsp),
        .entry         (entry),
        .hit           (hit),
        .store_capture (store_capture),
        .store_release (store_release)
    );

endmodule : evict_buffer

/* verification/wb_mem_model.sv */
module wb_mem_model (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp,
    output int unsigned     writes_seen
);

    logic [wb_pkg::DATA_W-1:0] mem [0:(1 << wb_pkg::ADDR_W)-1];
    logic [wb_pkg::DATA_W-1:0] merged;
    logic [wb_pkg::ADDR_W-1:0] fill_adr;

    integer      seed     = 32'h8168_9c82;
    int unsigned delay    = 0;
    int unsigned wait_cnt = 0;

    // Preset contents, every field of the line tied to its address
    initial begin
        for (int i = 0; i < (1 << wb_pkg::ADDR_W); i++) begin
            fill_adr = i[wb_pkg::ADDR_W-1:0];
            mem[fill_adr] = {20'hA5C3E, fill_adr, 20'h5B1D7, ~fill_adr,
                             20'h3E96F, fill_adr ^ 12'h5A5, 20'h6D24B, fill_adr ^ 12'hC3C};
        end
    end

    // Ack after 0 to 3 wait cycles, data read straight from the array
    assign rsp.ack = req.stb && (wait_cnt == delay);
    assign rsp.dat = mem[req.adr];

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt    <= 0;
            writes_seen <= 0;
        end else if (rsp.ack) begin
            if (req.we) begin
                merged = mem[req.adr];
                for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                    if (req.sel[b]) begin
                        merged[b*8 +: 8] = req.dat[b*8 +: 8];
                    end
                end
                mem[req.adr] <= merged;
                writes_seen  <= writes_seen + 1;
            end
            wait_cnt <= 0;
            delay    <= $unsigned($random(seed)) % 4;
        end else if (req.stb) begin
            wait_cnt <= wait_cnt + 1;
        end
    end

endmodule : wb_mem_model

/* verification/evict_buffer_tb.sv */
module evict_buffer_tb;

    localparam int NUM_ROWS    = 12;
    localparam int CYCLE_LIMIT = NUM_ROWS * 20 + 50;

    // One stimulus row with its expected read data
    typedef struct packed {
        logic                      is_write;
        logic [wb_pkg::ADDR_W-1:0] adr;
        logic [wb_pkg::DATA_W-1:0] dat;
        logic                      check;
        logic [wb_pkg::DATA_W-1:0] exp;
    } stim_row_t;

    logic            clk = 1'b0;
    logic            reset;
    wb_pkg::wb_req_t cache_req;
    wb_pkg::wb_rsp_t cache_rsp;
    wb_pkg::wb_req_t mem_req;
    wb_pkg::wb_rsp_t mem_rsp;
    int unsigned     writes_seen;

    stim_row_t rows [NUM_ROWS];

    // Reference model of all writes seen so far plus the line still held
    logic [wb_pkg::DATA_W-1:0] written [logic [wb_pkg::ADDR_W-1:0]];
    logic [wb_pkg::ADDR_W-1:0] pend_adr;
    logic [wb_pkg::DATA_W-1:0] pend_dat;
    int unsigned               accepted = 0;
    logic                      drain_on = 1'b0;

    int errors = 0;
    int failed_tests = 0;
    int cycles = 0;

    always #10 clk = ~clk;

    evict_buffer dut_i (
        .clk      (clk),
        .reset    (reset),
        .orig_req (cache_req),
        .orig_rsp (cache_rsp),
        .dest_req (mem_req),
        .dest_rsp (mem_rsp)
    );

    wb_mem_model mem_i (
        .clk         (clk),
        .reset       (reset),
        .req         (mem_req),
        .rsp         (mem_rsp),
        .writes_seen (writes_seen)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no acknowledge within %0d cycles, run stopped", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [wb_pkg::DATA_W-1:0] preset_line(logic [wb_pkg::ADDR_W-1:0] a);
        return {20'hA5C3E, a, 20'h5B1D7, ~a, 20'h3E96F, a ^ 12'h5A5, 20'h6D24B, a ^ 12'hC3C};
    endfunction

    function automatic logic [wb_pkg::DATA_W-1:0] model_line(logic [wb_pkg::ADDR_W-1:0] a);
        if (written.exists(a)) begin
            return written[a];
        end
        return preset_line(a);
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic load_rows;
        rows[0]  = '{1'b0, 12'h010, 128'h0, 1'b1, preset_line(12'h010)};
        rows[1]  = '{1'b1, 12'h020, 128'h0123_4567_89AB_CDEF_F0E1_D2C3_B4A5_9687, 1'b0, 128'h0};
        rows[2]  = '{1'b0, 12'h020, 128'h0, 1'b1, 128'h0123_4567_89AB_CDEF_F0E1_D2C3_B4A5_9687};
        rows[3]  = '{1'b0, 12'h030, 128'h0, 1'b1, preset_line(12'h030)};
        rows[4]  = '{1'b1, 12'h040, 128'h1357_9BDF_2468_ACE0_0F1E_2D3C_4B5A_6978, 1'b0, 128'h0};
        rows[5]  = '{1'b1, 12'h050, 128'hFEDC_BA98_7654_3210_8899_AABB_CCDD_EEFF, 1'b0, 128'h0};
        rows[6]  = '{1'b0, 12'h040, 128'h0, 1'b1, 128'h1357_9BDF_2468_ACE0_0F1E_2D3C_4B5A_6978};
        rows[7]  = '{1'b0, 12'h050, 128'h0, 1'b1, 128'hFEDC_BA98_7654_3210_8899_AABB_CCDD_EEFF};
        rows[8]  = '{1'b1, 12'h020, 128'h5555_AAAA_3333_CCCC_0F0F_F0F0_1234_5678, 1'b0, 128'h0};
        rows[9]  = '{1'b0, 12'h020, 128'h0, 1'b1, 128'h5555_AAAA_3333_CCCC_0F0F_F0F0_1234_5678};
        rows[10] = '{1'b0, 12'h010, 128'h0, 1'b1, preset_line(12'h010)};
        rows[11] = '{1'b0, 12'h050, 128'h0, 1'b1, 128'hFEDC_BA98_7654_3210_8899_AABB_CCDD_EEFF};
    endtask

    // Runs from one falling edge to the next and checks mid-cycle
    task automatic run_cycle(output logic acked, output logic [wb_pkg::DATA_W-1:0] rdata);
        logic pending;
        logic draining;
        logic wr;
        logic rd_hit;
        logic rd_miss;
        #5;
        pending = (writes_seen != accepted);
        if (!pending) begin
            drain_on = 1'b0;
        end
        draining = pending && drain_on;
        wr       = cache_req.stb && cache_req.we;
        rd_hit   = cache_req.stb && !cache_req.we && pending && (cache_req.adr == pend_adr);
        rd_miss  = cache_req.stb && !cache_req.we && !rd_hit;

        if (writes_seen > accepted) begin
            note_error("memory saw a write that no accepted line explains");
        end

        // Memory port carries the drain write first, then a pass-through read
        if (draining) begin
            if (!(mem_req.cyc && mem_req.stb && mem_req.we) || mem_req.adr !== pend_adr
                    || mem_req.sel !== '1 || mem_req.dat !== pend_dat) begin
                note_error($sformatf("drain write of line %03h not on memory port", pend_adr));
            end
        end else if (rd_miss) begin
            if (mem_req !== cache_req) begin
                note_error($sformatf("read of %03h not passed to memory", cache_req.adr));
            end
        end else if (mem_req.stb) begin
            note_error("memory port strobed with nothing to send");
        end

        // Cache side acknowledge
        if (!cache_req.stb) begin
            if (cache_rsp.ack) begin
                note_error("ack high without a request");
            end
        end else if (wr) begin
            if (cache_rsp.ack !== !pending) begin
                note_error($sformatf("write ack %0b, expected %0b", cache_rsp.ack, !pending));
            end
        end else if (rd_hit) begin
            if (!cache_rsp.ack) begin
                note_error("read hit not acknowledged in its first cycle");
            end
        end else if (draining) begin
            if (cache_rsp.ack) begin
                note_error("read miss acknowledged before the drain write reached memory");
            end
        end

        if (cache_req.stb && !cache_req.we && cache_rsp.ack) begin
            if (cache_rsp.dat !== model_line(cache_req.adr)) begin
                note_error($sformatf("read %03h returned %h, expected %h", cache_req.adr,
                                     cache_rsp.dat, model_line(cache_req.adr)));
            end
        end

        acked = cache_rsp.ack;
        rdata = cache_rsp.dat;

        // Model update for the edge that closes this cycle
        if (wr && cache_rsp.ack) begin
            accepted++;
            pend_adr = cache_req.adr;
            pend_dat = cache_req.dat;
            written[cache_req.adr] = cache_req.dat;
            drain_on = 1'b0;
        end else if (pending && !(rd_miss && !drain_on)) begin
            drain_on = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin
        logic                      acked;
        logic [wb_pkg::DATA_W-1:0] rdata;
        int                        errs_before;
        int                        n;
        reset     = 1'b1;
        cache_req = '0;
        load_rows();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet bus after reset
        repeat (3) run_cycle(acked, rdata);

        for (int i = 0; i < NUM_ROWS; i++) begin
            errs_before   = errors;
            n             = 0;
            cache_req.cyc = 1'b1;
            cache_req.stb = 1'b1;
            cache_req.we  = rows[i].is_write;
            cache_req.sel = '1;
            cache_req.adr = rows[i].adr;
            cache_req.dat = rows[i].dat;
            acked = 1'b0;
            while (!acked) begin
                run_cycle(acked, rdata);
                n++;
            end
            if (rows[i].check && rdata !== rows[i].exp) begin
                note_error($sformatf("test %0d read %h, table expects %h", i, rdata, rows[i].exp));
            end
            if (errors != errs_before) begin
                failed_tests++;
            end
            $display("test %0d: %s %03h %s after %0d cycles", i,
                     rows[i].is_write ? "write" : "read", rows[i].adr,
                     (errors == errs_before) ? "ok" : "FAILED", n);
        end

        // Let the last line reach memory
        cache_req = '0;
        while (writes_seen != accepted) begin
            run_cycle(acked, rdata);
        end

        $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : evict_buffer_tb

/* sources.f */
design/wb_pkg.sv
design/evict_pkg.sv
design/evict_line_store.sv
design/evict_control.sv
design/evict_buffer.sv
verification/wb_mem_model.sv
verification/evict_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the evict_buffer testbench with Verilator
rm -f build.log sim.log
verilator --binary --timing --assert --top-module evict_buffer_tb \
    -f sources.f -Mdir obj_dir -o evict_buffer_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/evict_buffer_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
exit 0
